// ==== build.f ====
rtl/waveform_pkg.sv
rtl/line_code_pkg.sv
rtl/phase_counter.sv
rtl/duty_cycle_generator.sv
rtl/bit_serializer.sv
rtl/manchester_transmitter.sv
test/manchester_transmitter_tb.sv

// ==== rtl/bit_serializer.sv ====
module bit_serializer (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     send,        // One-cycle pulse with a new word
    input  line_code_pkg::data_word_t data,        // Word to send, valid with send
    input  logic                     finish,      // Generator ended a bit's waveform
    output logic                     start,       // Begin the waveform of the next bit
    output logic                     first_phase, // Bit value for that waveform
    output logic                     busy,        // A word is on the line
    output logic                     word_done    // Last bit of the word has ended
);

    localparam int msb = line_code_pkg::word_width - 1;

    line_code_pkg::ser_state_t state;
    line_code_pkg::bit_index_t bits_left;  // Bits still to follow the one on the line
    line_code_pkg::data_word_t shift_word; // Remaining bits, next one in the MSB

    logic accept;  // A send that is taken
    logic advance; // A bit ends and another one follows

    always_comb begin
        accept    = send && (state == line_code_pkg::ser_idle); // Sends while busy are dropped
        advance   = finish && (state == line_code_pkg::ser_sending) && (bits_left != '0);
        word_done = finish && (state == line_code_pkg::ser_sending) && (bits_left == '0);
        start     = accept || advance; // Finish loops straight back to start
        busy      = (state == line_code_pkg::ser_sending);
    end

    // The first bit is taken straight from the host so that start and its bit
    // reach the generator in the send cycle
    always_comb begin
        if (state == line_code_pkg::ser_idle) begin
            first_phase = data[msb];
        end else begin
            first_phase = shift_word[msb];
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= line_code_pkg::ser_idle;
            bits_left <= '0;
        end else if (accept) begin
            state     <= line_code_pkg::ser_sending;
            bits_left <= line_code_pkg::bit_index_t'(msb); // MSB already on its way
        end else if (advance) begin
            bits_left <= bits_left - 1'b1;
        end else if (word_done) begin
            state     <= line_code_pkg::ser_idle; // busy drops in the next cycle
        end
    end

    // The MSB leaves with the send itself, so only the remaining bits are kept
    always_ff @(posedge clock) begin
        if (accept) begin
            shift_word <= {data[msb-1:0], 1'b0};
        end else if (advance) begin
            shift_word <= {shift_word[msb-1:0], 1'b0}; // Next bit moves up to the MSB
        end
    end

endmodule

// ==== rtl/duty_cycle_generator.sv ====
module duty_cycle_generator (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      start,       // One-cycle pulse, begins a waveform
    input  logic                      first_phase, // 1 puts the high phase first
    input  waveform_pkg::phase_count_t high_cycles, // Length of the high phase
    input  waveform_pkg::phase_count_t low_cycles,  // Length of the low phase
    output logic                      finish,      // High in the last cycle of a waveform
    output logic                      wave         // The generated waveform
);

    waveform_pkg::gen_state_t state;      // Phase being output now
    waveform_pkg::gen_state_t state_next;

    logic                      phase_done; // Counter is in the last cycle of the phase
    logic                      load;       // Entering a phase this cycle
    waveform_pkg::phase_count_t load_count; // Length of the phase being entered
    logic                      high_next;  // Next phase is a high one

    phase_counter phase_duration (
        .clock      (clock),
        .arst_n     (arst_n),
        .load       (load),
        .load_count (load_count),
        .last_cycle (phase_done)
    );

    // Actions, independent of state
    logic start_low;  // Start with the low phase first
    logic start_high; // Start with the high phase first

    always_comb begin
        start_low  = start && !first_phase;
        start_high = start &&  first_phase;
    end

    // Edges of the state diagram.
    // Both second phases behave alike when they end, so they share one set.
    logic idle_start_low;    // Idle, begin a low-first waveform
    logic idle_start_high;   // Idle, begin a high-first waveform
    logic low_done_to_high;  // Low first phase ends, high phase follows
    logic high_done_to_low;  // High first phase ends, low phase follows
    logic second_done;       // Either second phase ends
    logic second_start_low;  // Second phase ends and a low-first waveform follows at once
    logic second_start_high; // Same, for a high-first waveform
    logic second_stop;       // Second phase ends and nothing follows

    always_comb begin
        idle_start_low    = (state == waveform_pkg::idle)       && start_low;
        idle_start_high   = (state == waveform_pkg::idle)       && start_high;
        low_done_to_high  = (state == waveform_pkg::low_first)  && phase_done;
        high_done_to_low  = (state == waveform_pkg::high_first) && phase_done;
        second_done       = ((state == waveform_pkg::high_second) ||
                             (state == waveform_pkg::low_second)) && phase_done;
        second_start_low  = second_done && start_low;
        second_start_high = second_done && start_high;
        second_stop       = second_done && !start;
    end

    // Next state from the edges. At most one edge is active in any cycle
    always_comb begin
        state_next = state; // Stay put until the phase runs out
        if (idle_start_low || second_start_low) begin
            state_next = waveform_pkg::low_first;
        end
        if (idle_start_high || second_start_high) begin
            state_next = waveform_pkg::high_first;
        end
        if (low_done_to_high) begin
            state_next = waveform_pkg::high_second;
        end
        if (high_done_to_low) begin
            state_next = waveform_pkg::low_second;
        end
        if (second_stop) begin
            state_next = waveform_pkg::idle; // Line goes low and waits
        end
    end

    // Every edge except the stop enters a new phase and reloads the counter
    always_comb begin
        load       = idle_start_low || idle_start_high || second_start_low ||
                     second_start_high || low_done_to_high || high_done_to_low;
        high_next  = (state_next == waveform_pkg::high_first) ||
                     (state_next == waveform_pkg::high_second);
        load_count = high_next ? high_cycles : low_cycles;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= waveform_pkg::idle;
            wave  <= 1'b0;
        end else begin
            state <= state_next;
            wave  <= high_next; // Follows the state register, so no decode glitches
        end
    end

    // The last cycle of the second phase ends the waveform.
    // A caller that loops this back to start gets back-to-back waveforms.
    assign finish = second_done;

endmodule

// ==== rtl/line_code_pkg.sv ====
package line_code_pkg;

    localparam int word_width      = 8;                   // Bits sent per word
    localparam int bit_index_width = $clog2(word_width);  // Enough to count the bits left

    typedef logic [word_width-1:0]      data_word_t;      // Word as given by the host
    typedef logic [bit_index_width-1:0] bit_index_t;      // Bits still to send after this one

    // The serializer is either waiting for a word or walking through one
    typedef enum logic {
        ser_idle,    // Waiting for send
        ser_sending  // One waveform per bit, MSB first
    } ser_state_t;

endpackage

// ==== rtl/manchester_transmitter.sv ====
module manchester_transmitter (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      send,        // One-cycle pulse, takes data
    input  line_code_pkg::data_word_t  data,        // Word to send, MSB first
    input  waveform_pkg::phase_count_t high_cycles, // Equal counts give Manchester code
    input  waveform_pkg::phase_count_t low_cycles,  // Both must be 1 or more
    output logic                      line_out,    // Encoded line
    output logic                      busy,        // Word in progress
    output logic                      word_done    // Pulse in the last cycle of a word
);

    logic start;       // Serializer asks for a waveform
    logic first_phase; // Bit value of that waveform
    logic finish;      // Generator ended a waveform

    // Walks through the word and keeps the generator fed
    bit_serializer serializer_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .send        (send),
        .data        (data),
        .finish      (finish),
        .start       (start),
        .first_phase (first_phase),
        .busy        (busy),
        .word_done   (word_done)
    );

    // One two-phase waveform per bit, restarted on its own finish while
    // bits remain, so consecutive bits join without a gap
    duty_cycle_generator generator_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .start       (start),
        .first_phase (first_phase),
        .high_cycles (high_cycles),
        .low_cycles  (low_cycles),
        .finish      (finish),
        .wave        (line_out)
    );

endmodule

// ==== rtl/phase_counter.sv ====
module phase_counter (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      load,       // Start a new phase
    input  waveform_pkg::phase_count_t load_count, // Length of that phase
    output logic                      last_cycle  // High in the final cycle of the phase
);

    // A count of one marks the last cycle, so a phase of N cycles runs N down to 1
    localparam waveform_pkg::phase_count_t count_one =
        {{(waveform_pkg::count_width-1){1'b0}}, 1'b1};

    waveform_pkg::phase_count_t count; // Cycles left in the current phase

    // Counting stops at zero, which is where the counter rests while the
    // generator is idle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_count; // First cycle of the phase shows the full length
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Decoded straight from the register, so the generator sees it in the same
    // cycle and can switch phase with no idle cycle in between
    assign last_cycle = (count == count_one);

endmodule

// ==== rtl/waveform_pkg.sv ====
package waveform_pkg;

    // Phase lengths are counted in clock cycles, so this sets the longest phase
    localparam int count_width = 8;

    typedef logic [count_width-1:0] phase_count_t; // Length of one phase in cycles

    // Every waveform is one low and one high phase, in either order.
    // The encodings 5 to 7 are never reached.
    typedef enum logic [2:0] {
        idle        = 3'd0, // No waveform, output low
        low_first   = 3'd1, // Low phase of a waveform that started low
        high_second = 3'd2, // High phase that closes a low-first waveform
        high_first  = 3'd3, // High phase of a waveform that started high
        low_second  = 3'd4  // Low phase that closes a high-first waveform
    } gen_state_t;

endpackage

// ==== test/manchester_transmitter_tb.sv ====
module manchester_transmitter_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int  num_words      = 12;  // Words sent over the whole run
    localparam int  max_bit_cycles = 30;  // H plus L at their largest
    localparam int  timeout_cycles = num_words * line_code_pkg::word_width * max_bit_cycles + 200;
    localparam time drive_delay    = 2ns; // Inputs change this long after the rising edge

    logic                       clock = 1'b0;
    logic                       arst_n;
    logic                       send;
    line_code_pkg::data_word_t  data;
    waveform_pkg::phase_count_t high_cycles;
    waveform_pkg::phase_count_t low_cycles;
    logic                       line_out;
    logic                       busy;
    logic                       word_done;

    logic        exp_line = 1'b0; // Model outputs for the current cycle
    logic        exp_busy = 1'b0;
    logic        exp_done = 1'b0;
    logic        line_q[$];       // Line levels still to come for the word in flight
    logic [31:0] lcg_state = 32'd82;
    int          cycle_count = 0;
    string       test_name = "reset";

    manchester_transmitter dut_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .send        (send),
        .data        (data),
        .high_cycles (high_cycles),
        .low_cycles  (low_cycles),
        .line_out    (line_out),
        .busy        (busy),
        .word_done   (word_done)
    );

    always #20 clock = ~clock; // 40 ns period

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Upper bits of the generator are the better mixed ones
    function automatic waveform_pkg::phase_count_t random_count();
        return waveform_pkg::phase_count_t'(1 + (lcg_next() >> 16) % 15); // 1 to 15
    endfunction

    function automatic line_code_pkg::data_word_t random_word();
        return line_code_pkg::data_word_t'(lcg_next() >> 16);
    endfunction

    task automatic next_cycle();
        @(posedge clock);
        #drive_delay;
    endtask

    task automatic report_mismatch(input string signal_name, input logic expected,
                                   input logic actual);
        $display("[FAIL] %s: %s expected %b actual %b", test_name, signal_name,
                 expected, actual);
        $display("TEST FAIL");
        $fatal(1, "Output did not match the reference model");
    endtask

    // Expected line for the whole word, built from the top level timing rule.
    // Bit i fills cycles t+1+i*(H+L) through t+(i+1)*(H+L), and word_done
    // comes with the last of them
    always @(posedge clock or negedge arst_n) begin : reference_model
        int b;
        int c;
        if (!arst_n) begin
            line_q.delete();
            exp_line = 1'b0;
            exp_busy = 1'b0;
            exp_done = 1'b0;
        end else begin
            if (send && !exp_busy) begin // A send while busy is dropped
                for (b = line_code_pkg::word_width - 1; b >= 0; b--) begin
                    if (data[b]) begin
                        for (c = 0; c < high_cycles; c++) begin
                            line_q.push_back(1'b1);
                        end
                        for (c = 0; c < low_cycles; c++) begin
                            line_q.push_back(1'b0);
                        end
                    end else begin
                        for (c = 0; c < low_cycles; c++) begin
                            line_q.push_back(1'b0);
                        end
                        for (c = 0; c < high_cycles; c++) begin
                            line_q.push_back(1'b1);
                        end
                    end
                end
            end
            if (line_q.size() > 0) begin
                exp_line = line_q.pop_front();
                exp_busy = 1'b1;
                exp_done = (line_q.size() == 0); // Last cycle of the last bit
            end else begin
                exp_line = 1'b0; // Line rests low between words
                exp_busy = 1'b0;
                exp_done = 1'b0;
            end
        end
    end

    // Outputs and model are both settled in the middle of the cycle
    line_check: assert property (@(negedge clock) line_out === exp_line)
        else report_mismatch("line_out", exp_line, line_out);

    busy_check: assert property (@(negedge clock) busy === exp_busy)
        else report_mismatch("busy", exp_busy, busy);

    done_check: assert property (@(negedge clock) word_done === exp_done)
        else report_mismatch("word_done", exp_done, word_done);

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Run timed out after %0d cycles without finishing all words",
                     cycle_count);
            $display("TEST FAIL");
            $fatal(1, "Timeout");
        end
    end

    // Sends one word once the line is idle and waits for its word_done.
    // With extra_send a second send lands somewhere inside the word
    task automatic transmit_word(input string name, input line_code_pkg::data_word_t word,
                                 input waveform_pkg::phase_count_t h,
                                 input waveform_pkg::phase_count_t l, input logic extra_send);
        int gap;
        int offset;
        gap = 1 + int'(lcg_next() % 3);
        do @(negedge clock); while (busy);
        next_cycle();
        test_name = name;
        repeat (gap) next_cycle(); // A few idle cycles on the line
        data        = word;
        high_cycles = h; // Held until the next word
        low_cycles  = l;
        send        = 1'b1;
        next_cycle();
        send = 1'b0;
        data = random_word(); // Data only counts with send
        if (extra_send) begin
            offset = 1 + int'(lcg_next() % (h + l)); // Always well before the last bit
            repeat (offset) next_cycle();
            data = ~word;
            send = 1'b1;
            next_cycle();
            send = 1'b0;
        end
        do @(negedge clock); while (!word_done);
    endtask

    initial begin
        line_code_pkg::data_word_t  word;
        waveform_pkg::phase_count_t h;
        waveform_pkg::phase_count_t l;
        int                         n;
        arst_n      = 1'b0;
        send        = 1'b0;
        data        = '0;
        high_cycles = 8'd1;
        low_cycles  = 8'd1;
        repeat (3) @(posedge clock);
        #drive_delay;
        arst_n = 1'b1;
        next_cycle(); // Outputs still checked low here

        word = random_word();
        h    = random_count();
        transmit_word("manchester_word", word, h, h, 1'b0); // Equal phases

        word = random_word();
        h    = random_count();
        l    = random_count();
        if (l == h) begin
            l = (h == 8'd15) ? 8'd1 : h + 8'd1; // Force a real duty cycle
        end
        transmit_word("duty_word", word, h, l, 1'b0);

        word = random_word();
        h    = random_count();
        l    = random_count();
        transmit_word("busy_send", word, h, l, 1'b1);

        for (n = 3; n < num_words; n++) begin
            word = random_word();
            h    = random_count();
            l    = random_count();
            transmit_word($sformatf("random_word_%0d", n), word, h, l, 1'b1);
        end

        do @(negedge clock); while (busy);
        repeat (4) next_cycle(); // Line must stay low after the last word
        $display("TEST PASS");
        $finish;
    end

endmodule
